//--- logic/gb_screen_pkg.sv
package gb_screen_pkg;

    //////////////////////////////
    // Console screen geometry
    //////////////////////////////

    // Pixels per console line
    localparam int GB_WIDTH = 160;

    // Lines per console frame
    localparam int GB_HEIGHT = 144;

    // One shade per console pixel
    localparam int GB_PIXELS = GB_WIDTH * GB_HEIGHT;

    //////////////////////////////
    // Pixel and address types
    //////////////////////////////

    // Shade 0 is the lightest, 3 the darkest
    typedef logic [1:0] shade_t;

    // Linear address y*160 + x
    typedef logic [14:0] fb_addr_t;

    // Strobe and levels straight from the PPU
    typedef struct packed {
        shade_t pixel;
        logic   valid;
        logic   hblank;
        logic   vblank;
    } ppu_strobe_t;

    // One framebuffer write request
    typedef struct packed {
        logic     en;
        fb_addr_t addr;
        shade_t   data;
    } fb_write_t;

endpackage

//--- logic/display_pkg.sv
package display_pkg;

    //////////////////////////////
    // 640x480 raster
    //////////////////////////////

    // Full line including blanking
    localparam int H_TOTAL = 800;

    // Full frame including blanking
    localparam int V_TOTAL = 525;

    // Visible area
    localparam int H_ACTIVE = 640;
    localparam int V_ACTIVE = 480;

    //////////////////////////////
    // Pixel types
    //////////////////////////////

    // Enough for 0..799 and 0..524
    typedef logic [9:0] coord_t;

    // 8 bits each of red, green, blue
    typedef logic [23:0] rgb_t;

    // Dark grey around the console picture
    localparam rgb_t BORDER_RGB = 24'h383840;

    // One output pixel with its raster position
    typedef struct packed {
        logic   de;
        coord_t cx;
        coord_t cy;
        rgb_t   rgb;
    } video_out_t;

endpackage

//--- logic/ppu_capture.sv
`timescale 1ns/10ps

module ppu_capture (
    input  logic                      clk_pixel,
    input  logic                      reset_pixel,
    input  gb_screen_pkg::ppu_strobe_t ppu,
    output gb_screen_pkg::fb_write_t   fb_write
);
    import gb_screen_pkg::*;

    localparam fb_addr_t LINE_LEN = fb_addr_t'(GB_WIDTH);

    // Position of the next pixel the PPU sends
    logic [7:0] x;
    logic [7:0] y;
    logic       prev_hblank;
    logic       hblank_rise;

    logic     wr_en;
    fb_addr_t wr_addr;
    shade_t   wr_data;

    assign hblank_rise = ppu.hblank && !prev_hblank;

    //////////////////////////////
    // Position tracking
    //////////////////////////////
    always_ff @(posedge clk_pixel) begin
        if (reset_pixel) begin
            x           <= '0;
            y           <= '0;
            prev_hblank <= 1'b0;
        end else begin
            prev_hblank <= ppu.hblank;
            if (ppu.vblank) begin
                x <= '0;
                y <= '0;
            end else if (hblank_rise) begin
                x <= '0;
                y <= y + 8'd1;
            end else if (ppu.valid) begin
                x <= x + 8'd1;
            end
        end
    end

    //////////////////////////////
    // Registered write request
    //////////////////////////////
    always_ff @(posedge clk_pixel) begin
        if (reset_pixel) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= ppu.valid;
        end
    end

    // Address and shade only matter while wr_en is high
    always_ff @(posedge clk_pixel) begin
        if (ppu.valid) begin
            wr_addr <= fb_addr_t'(y) * LINE_LEN + fb_addr_t'(x);
            wr_data <= ppu.pixel;
        end
    end

    assign fb_write = '{en: wr_en, addr: wr_addr, data: wr_data};

endmodule

//--- logic/framebuffer.sv
`timescale 1ns/10ps

module framebuffer (
    input  logic                    clk_pixel,
    input  logic                    reset_pixel,
    input  gb_screen_pkg::fb_write_t fb_write,
    input  gb_screen_pkg::fb_addr_t  rd_addr,
    output gb_screen_pkg::shade_t    rd_data
);
    import gb_screen_pkg::*;

    // One shade per console pixel
    shade_t mem [GB_PIXELS];

    // Array output register
    shade_t mem_q;

    // Write port
    always_ff @(posedge clk_pixel) begin
        if (fb_write.en) begin
            mem[fb_write.addr] <= fb_write.data;
        end
    end

    // First read stage, old data on a same-address write
    always_ff @(posedge clk_pixel) begin
        mem_q <= mem[rd_addr];
    end

    // Second read stage
    always_ff @(posedge clk_pixel) begin
        if (reset_pixel) begin
            rd_data <= '0;
        end else begin
            rd_data <= mem_q;
        end
    end

endmodule

//--- logic/screen_composer.sv
`timescale 1ns/10ps

module screen_composer #(
    parameter int WINDOW_X = 240,
    parameter int WINDOW_Y = 168
) (
    input  logic                     clk_pixel,
    input  logic                     reset_pixel,
    output gb_screen_pkg::fb_addr_t  rd_addr,
    input  gb_screen_pkg::shade_t    rd_data,
    output display_pkg::video_out_t  video
);
    import gb_screen_pkg::*;
    import display_pkg::*;

    // Position and flags carried alongside the framebuffer read
    typedef struct packed {
        logic   de;
        logic   in_win;
        coord_t cx;
        coord_t cy;
    } stage_t;

    localparam coord_t   X_FIRST  = coord_t'(WINDOW_X);
    localparam coord_t   X_LAST   = coord_t'(WINDOW_X + GB_WIDTH - 1);
    localparam coord_t   Y_FIRST  = coord_t'(WINDOW_Y);
    localparam coord_t   Y_LAST   = coord_t'(WINDOW_Y + GB_HEIGHT - 1);
    localparam coord_t   X_END    = coord_t'(H_TOTAL - 1);
    localparam coord_t   Y_END    = coord_t'(V_TOTAL - 1);
    localparam coord_t   X_VIS    = coord_t'(H_ACTIVE);
    localparam coord_t   Y_VIS    = coord_t'(V_ACTIVE);
    localparam fb_addr_t LINE_LEN = fb_addr_t'(GB_WIDTH);

    coord_t cx;
    coord_t cy;
    coord_t win_x;
    coord_t win_y;
    logic   in_win;
    logic   de;

    stage_t stage_now;
    stage_t stage_1;
    stage_t stage_2;

    //////////////////////////////
    // Raster counters
    //////////////////////////////
    always_ff @(posedge clk_pixel) begin
        if (reset_pixel) begin
            cx <= '0;
            cy <= '0;
        end else if (cx == X_END) begin
            cx <= '0;
            cy <= (cy == Y_END) ? '0 : cy + 10'd1;
        end else begin
            cx <= cx + 10'd1;
        end
    end

    //////////////////////////////
    // Window test and read
    //////////////////////////////
    assign in_win = (cx >= X_FIRST) && (cx <= X_LAST) && (cy >= Y_FIRST) && (cy <= Y_LAST);
    assign de     = (cx < X_VIS) && (cy < Y_VIS);

    // Offsets from the window origin
    assign win_x = cx - X_FIRST;
    assign win_y = cy - Y_FIRST;

    // Park the address at 0 outside the window so it stays in range
    assign rd_addr = in_win ? fb_addr_t'(win_y) * LINE_LEN + fb_addr_t'(win_x) : '0;

    assign stage_now = '{de: de, in_win: in_win, cx: cx, cy: cy};

    //////////////////////////////
    // Delay pipeline and colour
    //////////////////////////////

    // Two stages match the framebuffer read, the third is the output
    always_ff @(posedge clk_pixel) begin
        if (reset_pixel) begin
            stage_1 <= '0;
            stage_2 <= '0;
            video   <= '0;
        end else begin
            stage_1   <= stage_now;
            stage_2   <= stage_1;
            video.de  <= stage_2.de;
            video.cx  <= stage_2.cx;
            video.cy  <= stage_2.cy;
            // Shade 0 maps to white
            video.rgb <= stage_2.in_win ? rgb_t'({12{~rd_data}}) : BORDER_RGB;
        end
    end

endmodule

//--- logic/gb_hdmi_picture.sv
`timescale 1ns/10ps

module gb_hdmi_picture #(
    parameter int WINDOW_X = 240,
    parameter int WINDOW_Y = 168
) (
    input  logic                       clk_pixel,
    input  logic                       reset_pixel,
    input  gb_screen_pkg::ppu_strobe_t ppu,
    output display_pkg::video_out_t    video
);
    import gb_screen_pkg::*;

    fb_write_t fb_write;
    fb_addr_t  rd_addr;
    shade_t    rd_data;

    //////////////////////////////
    // Console side
    //////////////////////////////
    ppu_capture ppu_capture_inst (
        .clk_pixel   (clk_pixel),
        .reset_pixel (reset_pixel),
        .ppu         (ppu),
        .fb_write    (fb_write)
    );

    framebuffer framebuffer_inst (
        .clk_pixel   (clk_pixel),
        .reset_pixel (reset_pixel),
        .fb_write    (fb_write),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data)
    );

    //////////////////////////////
    // Display side
    //////////////////////////////
    screen_composer #(
        .WINDOW_X (WINDOW_X),
        .WINDOW_Y (WINDOW_Y)
    ) screen_composer_inst (
        .clk_pixel   (clk_pixel),
        .reset_pixel (reset_pixel),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .video       (video)
    );

endmodule

//--- testbench/gb_hdmi_picture_chk.sv
`timescale 1ns/10ps

module gb_hdmi_picture_chk (
    input  logic                       clk_pixel,
    input  logic                       reset_pixel,
    input  gb_screen_pkg::ppu_strobe_t ppu,
    input  display_pkg::video_out_t    video
);
    import display_pkg::*;

    // Failed assertions, read back at the end of the run
    int fail_count = 0;

    //////////////////////////////
    // Output after reset
    //////////////////////////////
    assert property (@(posedge clk_pixel) reset_pixel |=> !video.de)
        else begin
            $error("video.de is high in the cycle after reset");
            fail_count++;
        end

    //////////////////////////////
    // PPU strobe rules
    //////////////////////////////
    assert property (@(posedge clk_pixel) disable iff (reset_pixel)
        !(ppu.valid && ppu.vblank))
        else begin
            $error("PPU valid strobe during vblank");
            fail_count++;
        end

    // A pixel never lands on the start of hblank
    assert property (@(posedge clk_pixel) disable iff (reset_pixel)
        !(ppu.valid && $rose(ppu.hblank)))
        else begin
            $error("PPU valid strobe on a rising hblank edge");
            fail_count++;
        end

    //////////////////////////////
    // Visible area
    //////////////////////////////
    assert property (@(posedge clk_pixel) disable iff (reset_pixel)
        video.de |-> (video.cx < coord_t'(H_ACTIVE)))
        else begin
            $error("video.de is high beyond the visible width");
            fail_count++;
        end

endmodule

//--- testbench/gb_hdmi_picture_tb.sv
`timescale 1ns/10ps

module gb_hdmi_picture_tb;
    import gb_screen_pkg::*;
    import display_pkg::*;

    localparam int WINDOW_X     = 240;
    localparam int WINDOW_Y     = 168;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    // Vblank, pixels with a gap every 8, hblank pulses, settling
    localparam int LOAD_CYCLES  = 4 + GB_HEIGHT * (GB_WIDTH + GB_WIDTH / 8 + 3) + 16;
    // Two loads, two probe sweeps of up to two frames each, one monitored frame
    localparam int TIMEOUT_CYCLES = 2 * LOAD_CYCLES + 5 * FRAME_CYCLES + 10000;

    logic        clk_pixel;
    logic        reset_pixel;
    ppu_strobe_t ppu;
    video_out_t  video;

    // Shades the loader sends, indexed [y][x]
    shade_t frame_ref [GB_HEIGHT][GB_WIDTH];

    // Probe table, kept in raster order so one sweep fits in one frame
    string  probe_name [$];
    coord_t probe_x [$];
    coord_t probe_y [$];

    int check_count = 0;
    int error_count = 0;
    int cycle_count = 0;

    gb_hdmi_picture #(
        .WINDOW_X (WINDOW_X),
        .WINDOW_Y (WINDOW_Y)
    ) gb_hdmi_picture_inst (
        .clk_pixel   (clk_pixel),
        .reset_pixel (reset_pixel),
        .ppu         (ppu),
        .video       (video)
    );

    bind gb_hdmi_picture gb_hdmi_picture_chk chk_inst (
        .clk_pixel   (clk_pixel),
        .reset_pixel (reset_pixel),
        .ppu         (ppu),
        .video       (video)
    );

    initial begin
        clk_pixel = 1'b0;
        forever #4 clk_pixel = ~clk_pixel;
    end

    //////////////////////////////
    // Checks and reference model
    //////////////////////////////
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Inverted shade inside the window, border colour elsewhere
    function automatic rgb_t expected_rgb(input coord_t x, input coord_t y);
        int wx;
        int wy;
        wx = int'(x) - WINDOW_X;
        wy = int'(y) - WINDOW_Y;
        if (wx >= 0 && wx < GB_WIDTH && wy >= 0 && wy < GB_HEIGHT) begin
            // Shade 0 is white, shade 3 is black
            case (frame_ref[wy][wx])
                2'd0:    return 24'hffffff;
                2'd1:    return 24'haaaaaa;
                2'd2:    return 24'h555555;
                default: return 24'h000000;
            endcase
        end
        return 24'h383840;
    endfunction

    task automatic add_probe(input string name, input int x, input int y);
        probe_name.push_back(name);
        probe_x.push_back(coord_t'(x));
        probe_y.push_back(coord_t'(y));
    endtask

    //////////////////////////////
    // PPU stimulus
    //////////////////////////////
    task automatic drive_strobe(input shade_t pixel, input logic valid,
                                input logic hblank, input logic vblank);
        @(posedge clk_pixel);
        #1;
        ppu = '{pixel: pixel, valid: valid, hblank: hblank, vblank: vblank};
    endtask

    // One console frame from frame_ref
    task automatic load_frame();
        repeat (4) drive_strobe(2'b00, 1'b0, 1'b0, 1'b1);
        for (int y = 0; y < GB_HEIGHT; y++) begin
            for (int x = 0; x < GB_WIDTH; x++) begin
                drive_strobe(frame_ref[y][x], 1'b1, 1'b0, 1'b0);
                if (x % 8 == 7) begin
                    drive_strobe(2'b00, 1'b0, 1'b0, 1'b0);
                end
            end
            if (y < GB_HEIGHT - 1) begin
                drive_strobe(2'b00, 1'b0, 1'b1, 1'b0);
                drive_strobe(2'b00, 1'b0, 1'b1, 1'b0);
                drive_strobe(2'b00, 1'b0, 1'b0, 1'b0);
            end
        end
        drive_strobe(2'b00, 1'b0, 1'b0, 1'b0);
        // Write path plus read pipeline
        repeat (8) @(posedge clk_pixel);
    endtask

    //////////////////////////////
    // Output observation
    //////////////////////////////
    task automatic wait_for_position(input coord_t x, input coord_t y);
        @(negedge clk_pixel);
        while (video.cx != x || video.cy != y) begin
            @(negedge clk_pixel);
        end
    endtask

    task automatic run_probes(input string tag);
        logic exp_de;
        for (int i = 0; i < probe_x.size(); i++) begin
            wait_for_position(probe_x[i], probe_y[i]);
            exp_de = (probe_x[i] < coord_t'(H_ACTIVE)) && (probe_y[i] < coord_t'(V_ACTIVE));
            check_value({tag, "_", probe_name[i], "_rgb"},
                        32'(expected_rgb(probe_x[i], probe_y[i])), 32'(video.rgb));
            check_value({tag, "_", probe_name[i], "_de"}, 32'(exp_de), 32'(video.de));
        end
    endtask

    // Positions step by one per cycle over a whole frame
    task automatic check_raster_frame();
        coord_t prev_x;
        coord_t prev_y;
        coord_t exp_x;
        coord_t exp_y;
        int     wraps;
        int     bad_steps;
        wraps     = 0;
        bad_steps = 0;
        @(negedge clk_pixel);
        prev_x = video.cx;
        prev_y = video.cy;
        repeat (FRAME_CYCLES) begin
            @(negedge clk_pixel);
            if (prev_x == coord_t'(H_TOTAL - 1)) begin
                exp_x = '0;
                exp_y = (prev_y == coord_t'(V_TOTAL - 1)) ? '0 : prev_y + 10'd1;
                wraps++;
            end else begin
                exp_x = prev_x + 10'd1;
                exp_y = prev_y;
            end
            if (video.cx != exp_x || video.cy != exp_y) begin
                bad_steps++;
            end
            prev_x = video.cx;
            prev_y = video.cy;
        end
        check_value("raster_bad_steps", 32'd0, 32'(bad_steps));
        check_value("raster_cx_wraps", 32'(V_TOTAL), 32'(wraps));
    endtask

    //////////////////////////////
    // Run limit
    //////////////////////////////
    always @(posedge clk_pixel) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Summary: %0d checks, %0d mismatches, %0d assertion failures",
                     check_count, error_count, gb_hdmi_picture_inst.chk_inst.fail_count);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    //////////////////////////////
    // Main sequence
    //////////////////////////////
    initial begin
        void'($urandom(32'h537737b2));
        ppu         = '0;
        reset_pixel = 1'b1;
        repeat (2) @(posedge clk_pixel);
        #1;
        reset_pixel = 1'b0;

        add_probe("border_origin", 0, 0);
        add_probe("border_above_win", 300, 100);
        add_probe("hblank_above_win", 700, 100);
        add_probe("win_top_left", 240, 168);
        add_probe("win_top_right", 399, 168);
        add_probe("border_left_of_win", 239, 200);
        add_probe("win_inner_a", 300, 200);
        add_probe("border_right_of_win", 400, 200);
        add_probe("win_inner_b", 333, 250);
        add_probe("win_left_edge", 240, 260);
        add_probe("win_right_edge", 399, 290);
        add_probe("win_bottom_left", 240, 311);
        add_probe("win_bottom_right", 399, 311);
        add_probe("border_below_win", 320, 312);
        add_probe("border_last_visible", 639, 479);
        add_probe("vblank_area", 100, 500);

        for (int y = 0; y < GB_HEIGHT; y++) begin
            for (int x = 0; x < GB_WIDTH; x++) begin
                frame_ref[y][x] = shade_t'($urandom());
            end
        end
        load_frame();
        run_probes("first");
        check_raster_frame();

        // Every shade changes, so stale pixels cannot pass
        for (int y = 0; y < GB_HEIGHT; y++) begin
            for (int x = 0; x < GB_WIDTH; x++) begin
                frame_ref[y][x] = ~frame_ref[y][x];
            end
        end
        load_frame();
        run_probes("second");

        $display("Summary: %0d checks, %0d mismatches, %0d assertion failures",
                 check_count, error_count, gb_hdmi_picture_inst.chk_inst.fail_count);
        if (error_count == 0 && gb_hdmi_picture_inst.chk_inst.fail_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- build.f
logic/gb_screen_pkg.sv
logic/display_pkg.sv
logic/ppu_capture.sv
logic/framebuffer.sv
logic/screen_composer.sv
logic/gb_hdmi_picture.sv
testbench/gb_hdmi_picture_chk.sv
testbench/gb_hdmi_picture_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the picture testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert \
    --timescale 1ns/10ps \
    --top-module gb_hdmi_picture_tb \
    -Mdir obj_dir \
    -f build.f

# Assertion errors are counted by the testbench instead of stopping the run
output=$(./obj_dir/Vgb_hdmi_picture_tb +verilator+error+limit+1000 2>&1) || true
echo "$output"

if echo "$output" | grep -qF '*** TEST PASSED ***'; then
    exit 0
else
    exit 1
fi
